// ==== hdl/mips_pkg.sv ====
//--------------------------------------------------
// Shared definitions for the MIPS subset core
// Instruction opcode and R-type funct enums
// ALU operation enum chosen by decode
// Memory word-address and register index widths
//--------------------------------------------------

package mips_pkg;

	// Instruction memory, 256 words
	localparam int IMEM_AW = 8;
	// Data memory, 256 words
	localparam int DMEM_AW = 8;
	localparam int REG_AW = 5;

	//--------------------------------------------------
	// Primary opcode, inst[31:26]
	//--------------------------------------------------
	typedef enum logic [5:0] {
		OP_R     = 6'b000000,
		OP_J     = 6'b000010,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_ADDI  = 6'b001000,
		OP_ADDIU = 6'b001001,
		OP_SLTI  = 6'b001010,
		OP_ANDI  = 6'b001100,
		OP_ORI   = 6'b001101,
		OP_XORI  = 6'b001110,
		OP_LUI   = 6'b001111,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011
	} opcode_e;

	//--------------------------------------------------
	// R-type function field, inst[5:0]
	//--------------------------------------------------
	typedef enum logic [5:0] {
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_SLT  = 6'b101010
	} funct_e;

	// ALU operation carried in ID/EX
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI,
		// No result, used by branches and unknown funct codes
		ALU_NONE
	} alu_op_e;

endpackage

// ==== hdl/if_stage.sv ====
//--------------------------------------------------
// Fetch stage
// Program counter and instruction memory with load port
// IF/ID pipeline register with hold and flush
//--------------------------------------------------

module if_stage (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         run,
	input  logic                         halt,
	input  logic                         hold,
	input  logic                         redirect,
	input  logic [31:0]                  redirect_pc,
	input  logic                         imem_we,
	input  logic [mips_pkg::IMEM_AW-1:0] imem_addr,
	input  logic [31:0]                  imem_wdata,
	output logic                         if_valid,
	output logic [31:0]                  if_pc,
	output logic [31:0]                  if_inst
);

	import mips_pkg::*;

	logic [31:0] imem [0:(2**IMEM_AW)-1];
	logic [31:0] pc;
	logic        advance;

	// Fetch moves only when running, not halted and not stalled
	assign advance = run && !halt && !hold;

	// Program load, only used while run is low
	always_ff @(posedge clk)
	begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= '0;
			if_valid <= 1'b0;
		end
		else if (redirect)
		begin
			// Flush the slot behind a taken branch or jump
			pc <= redirect_pc;
			if_valid <= 1'b0;
		end
		else if (!hold)
		begin
			// Without a new fetch the old entry has gone on to decode
			if_valid <= advance;
			if (advance)
				pc <= pc + 32'd4;
		end
	end

	// IF/ID payload
	always_ff @(posedge clk)
	begin
		if (advance && !redirect)
		begin
			if_pc <= pc;
			if_inst <= imem[pc[IMEM_AW+1:2]];
		end
	end

	a_redirect_aligned: assert property (@(posedge clk) disable iff (rst)
		redirect |-> (redirect_pc[1:0] == 2'b00))
		else $error("Branch or jump target is not word aligned");

endmodule

// ==== hdl/id_regfile.sv ====
//--------------------------------------------------
// Register file, 32 x 32 bits
// Two combinational read ports
// One write port on the falling clock edge
//--------------------------------------------------

module id_regfile (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [mips_pkg::REG_AW-1:0] rs_addr,
	input  logic [mips_pkg::REG_AW-1:0] rt_addr,
	output logic [31:0]                 rs_data,
	output logic [31:0]                 rt_data,
	input  logic                        wb_valid,
	input  logic [mips_pkg::REG_AW-1:0] wb_reg,
	input  logic [31:0]                 wb_data
);

	import mips_pkg::*;

	logic [31:0] regs [0:(2**REG_AW)-1];

	// Falling edge write makes a result visible to decode in the same cycle
	always_ff @(negedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 2**REG_AW; i++)
				regs[i] <= '0;
		end
		else if (wb_valid && (wb_reg != '0))
		begin
			regs[wb_reg] <= wb_data;
		end
	end

	// r0 reads as zero
	assign rs_data = (rs_addr == '0) ? 32'd0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? 32'd0 : regs[rt_addr];

endmodule

// ==== hdl/id_stage.sv ====
//--------------------------------------------------
// Decode stage
// Control decode and immediate extension
// Hazard interlock against the instruction in execute
// Branch and jump resolution with fetch redirect
// Sticky illegal opcode exception
// ID/EX pipeline register
//--------------------------------------------------

module id_stage (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        if_valid,
	input  logic [31:0]                 if_pc,
	input  logic [31:0]                 if_inst,
	output logic [mips_pkg::REG_AW-1:0] rs_addr,
	output logic [mips_pkg::REG_AW-1:0] rt_addr,
	input  logic [31:0]                 rs_data,
	input  logic [31:0]                 rt_data,
	output logic                        hold,
	output logic                        redirect,
	output logic [31:0]                 redirect_pc,
	output logic                        halt,
	output logic                        exception,
	output logic [31:0]                 exc_pc,
	output logic                        ex_valid,
	output mips_pkg::alu_op_e           ex_alu_op,
	output logic                        ex_use_imm,
	output logic [31:0]                 ex_imm,
	output logic [31:0]                 ex_rs_data,
	output logic [31:0]                 ex_rt_data,
	output logic [mips_pkg::REG_AW-1:0] ex_dest,
	output logic                        ex_reg_write,
	output logic                        ex_mem_read,
	output logic                        ex_mem_write
);

	import mips_pkg::*;

	opcode_e           op;
	funct_e            fn;
	alu_op_e           alu_op;
	logic              use_imm, reg_write, mem_read, mem_write;
	logic              dest_rt, zero_ext, uses_rs, uses_rt;
	logic              is_beq, is_bne, is_j, illegal;
	logic              id_valid, hazard, taken, issue;
	logic [REG_AW-1:0] dest;
	logic [31:0]       imm, pc_plus4;

	assign op = opcode_e'(if_inst[31:26]);
	assign fn = funct_e'(if_inst[5:0]);
	assign rs_addr = if_inst[25:21];
	assign rt_addr = if_inst[20:16];

	//--------------------------------------------------
	// Control decode
	//--------------------------------------------------
	always_comb
	begin
		alu_op = ALU_NONE;
		use_imm = 1'b0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		dest_rt = 1'b1;
		zero_ext = 1'b0;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_j = 1'b0;
		illegal = 1'b0;
		case (op)
			OP_R:
			begin
				dest_rt = 1'b0;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				reg_write = 1'b1;
				case (fn)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_SLT:  alu_op = ALU_SLT;
					// Unknown funct behaves as a no-op
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LW:
			begin
				use_imm = 1'b1;
				reg_write = 1'b1;
				uses_rs = 1'b1;
				mem_read = (op == OP_LW);
				zero_ext = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);
				case (op)
					OP_SLTI: alu_op = ALU_SLT;
					OP_ANDI: alu_op = ALU_AND;
					OP_ORI:  alu_op = ALU_OR;
					OP_XORI: alu_op = ALU_XOR;
					default: alu_op = ALU_ADD;
				endcase
			end
			OP_LUI:
			begin
				alu_op = ALU_LUI;
				use_imm = 1'b1;
				reg_write = 1'b1;
			end
			OP_SW:
			begin
				alu_op = ALU_ADD;
				use_imm = 1'b1;
				mem_write = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			OP_BEQ, OP_BNE:
			begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				is_beq = (op == OP_BEQ);
				is_bne = (op == OP_BNE);
			end
			OP_J:    is_j = 1'b1;
			default: illegal = 1'b1;
		endcase
	end

	assign dest = dest_rt ? if_inst[20:16] : if_inst[15:11];
	assign imm = zero_ext ? {16'h0000, if_inst[15:0]} : {{16{if_inst[15]}}, if_inst[15:0]};

	// Nothing is decoded once the exception is taken
	assign id_valid = if_valid && !exception;

	// Interlock, no forwarding path exists
	assign hazard = ex_valid && ex_reg_write && (ex_dest != '0)
		&& ((uses_rs && (ex_dest == rs_addr)) || (uses_rt && (ex_dest == rt_addr)));
	assign hold = id_valid && hazard;

	//--------------------------------------------------
	// Branch and jump resolution
	//--------------------------------------------------
	assign pc_plus4 = if_pc + 32'd4;
	assign taken = is_j || (is_beq && (rs_data == rt_data)) || (is_bne && (rs_data != rt_data));
	assign redirect = id_valid && !hazard && taken;
	assign redirect_pc = is_j ? {pc_plus4[31:28], if_inst[25:0], 2'b00}
		: pc_plus4 + {{14{if_inst[15]}}, if_inst[15:0], 2'b00};

	assign halt = exception || (id_valid && illegal);
	assign issue = id_valid && !hazard && !illegal;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			exception <= 1'b0;
			exc_pc <= '0;
		end
		else if (id_valid && illegal)
		begin
			exception <= 1'b1;
			exc_pc <= if_pc;
		end
	end

	// ID/EX control, a bubble on stall or illegal opcode
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ex_valid <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
		end
		else
		begin
			ex_valid <= issue;
			ex_reg_write <= issue && reg_write && (dest != '0);
			ex_mem_read <= issue && mem_read;
			ex_mem_write <= issue && mem_write;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk)
	begin
		ex_alu_op <= alu_op;
		ex_use_imm <= use_imm;
		ex_imm <= imm;
		ex_rs_data <= rs_data;
		ex_rt_data <= rt_data;
		ex_dest <= dest;
	end

	// A stalled instruction stays in IF/ID and leaves only a bubble in ID/EX
	a_hold_bubble: assert property (@(posedge clk) disable iff (rst)
		hold |=> (if_valid && $stable(if_pc) && $stable(if_inst) && !ex_valid))
		else $error("Stalled instruction left IF/ID or also entered ID/EX");

endmodule

// ==== hdl/ex_stage.sv ====
//--------------------------------------------------
// Execute stage
// ALU with register or immediate operand
// Data memory for word loads and stores
// Writeback and store report registers
//--------------------------------------------------

module ex_stage (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        ex_valid,
	input  mips_pkg::alu_op_e           ex_alu_op,
	input  logic                        ex_use_imm,
	input  logic [31:0]                 ex_imm,
	input  logic [31:0]                 ex_rs_data,
	input  logic [31:0]                 ex_rt_data,
	input  logic [mips_pkg::REG_AW-1:0] ex_dest,
	input  logic                        ex_reg_write,
	input  logic                        ex_mem_read,
	input  logic                        ex_mem_write,
	output logic                        wb_valid,
	output logic [mips_pkg::REG_AW-1:0] wb_reg,
	output logic [31:0]                 wb_data,
	output logic                        st_valid,
	output logic [31:0]                 st_addr,
	output logic [31:0]                 st_data
);

	import mips_pkg::*;

	logic [31:0]        dmem [0:(2**DMEM_AW)-1];
	logic [31:0]        op_b;
	logic [31:0]        alu_result;
	logic [DMEM_AW-1:0] dmem_idx;

	//--------------------------------------------------
	// ALU
	//--------------------------------------------------
	assign op_b = ex_use_imm ? ex_imm : ex_rt_data;

	always_comb
	begin
		case (ex_alu_op)
			ALU_ADD: alu_result = ex_rs_data + op_b;
			ALU_SUB: alu_result = ex_rs_data - op_b;
			ALU_AND: alu_result = ex_rs_data & op_b;
			ALU_OR:  alu_result = ex_rs_data | op_b;
			ALU_XOR: alu_result = ex_rs_data ^ op_b;
			ALU_SLT: alu_result = {31'd0, $signed(ex_rs_data) < $signed(op_b)};
			ALU_LUI: alu_result = {op_b[15:0], 16'h0000};
			default: alu_result = '0;
		endcase
	end

	// Byte address, low two bits ignored
	assign dmem_idx = alu_result[DMEM_AW+1:2];

	always_ff @(posedge clk)
	begin
		if (ex_valid && ex_mem_write)
			dmem[dmem_idx] <= ex_rt_data;
	end

	//--------------------------------------------------
	// Writeback and store report
	//--------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_valid <= 1'b0;
			st_valid <= 1'b0;
		end
		else
		begin
			wb_valid <= ex_valid && ex_reg_write;
			st_valid <= ex_valid && ex_mem_write;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_reg <= ex_dest;
		// Load data is taken at the edge that ends execute
		wb_data <= ex_mem_read ? dmem[dmem_idx] : alu_result;
		st_addr <= alu_result;
		st_data <= ex_rt_data;
	end

	a_one_commit: assert property (@(posedge clk) disable iff (rst)
		!(wb_valid && st_valid))
		else $error("Writeback and store reported in the same cycle");

endmodule

// ==== hdl/mips_core.sv ====
//--------------------------------------------------
// Top level of the MIPS subset core
// Fetch, decode with register file, execute
//--------------------------------------------------

module mips_core (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         run,
	input  logic                         imem_we,
	input  logic [mips_pkg::IMEM_AW-1:0] imem_addr,
	input  logic [31:0]                  imem_wdata,
	output logic                         wb_valid,
	output logic [mips_pkg::REG_AW-1:0]  wb_reg,
	output logic [31:0]                  wb_data,
	output logic                         st_valid,
	output logic [31:0]                  st_addr,
	output logic [31:0]                  st_data,
	output logic                         exception,
	output logic [31:0]                  exc_pc
);

	import mips_pkg::*;

	// Fetch to decode
	logic              if_valid;
	logic [31:0]       if_pc, if_inst;
	logic              hold, redirect, halt;
	logic [31:0]       redirect_pc;

	// Decode to register file
	logic [REG_AW-1:0] rs_addr, rt_addr;
	logic [31:0]       rs_data, rt_data;

	// ID/EX register
	logic              ex_valid, ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write;
	alu_op_e           ex_alu_op;
	logic [31:0]       ex_imm, ex_rs_data, ex_rt_data;
	logic [REG_AW-1:0] ex_dest;

	if_stage u_if_stage (
		.clk(clk), .rst(rst), .run(run), .halt(halt), .hold(hold),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.if_valid(if_valid), .if_pc(if_pc), .if_inst(if_inst)
	);

	id_regfile u_id_regfile (
		.clk(clk), .rst(rst), .rs_addr(rs_addr), .rt_addr(rt_addr),
		.rs_data(rs_data), .rt_data(rt_data),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	id_stage u_id_stage (
		.clk(clk), .rst(rst), .if_valid(if_valid), .if_pc(if_pc), .if_inst(if_inst),
		.rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
		.hold(hold), .redirect(redirect), .redirect_pc(redirect_pc),
		.halt(halt), .exception(exception), .exc_pc(exc_pc),
		.ex_valid(ex_valid), .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm),
		.ex_imm(ex_imm), .ex_rs_data(ex_rs_data), .ex_rt_data(ex_rt_data),
		.ex_dest(ex_dest), .ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write)
	);

	ex_stage u_ex_stage (
		.clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_alu_op(ex_alu_op),
		.ex_use_imm(ex_use_imm), .ex_imm(ex_imm),
		.ex_rs_data(ex_rs_data), .ex_rt_data(ex_rt_data), .ex_dest(ex_dest),
		.ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
		.st_valid(st_valid), .st_addr(st_addr), .st_data(st_data)
	);

endmodule

// ==== verif/tb_mips_core.sv ====
//--------------------------------------------------
// Testbench for the MIPS subset core
// Clock, reset and program loading
// ISA-level reference model of registers, memory, PC
// Commit checks as concurrent assertions
// Per-test report lines and watchdog
//--------------------------------------------------

module tb_mips_core;

	import mips_pkg::*;

	localparam int MAX_EVENTS = 512;
	localparam int RAND_LEN = 48;
	// Opcode 6'b111111 lies outside the subset and stops the core
	localparam logic [31:0] STOP_INST = 32'hFC00_0000;

	logic               clk = 1'b0;
	logic               rst;
	logic               run;
	logic               imem_we;
	logic [IMEM_AW-1:0] imem_addr;
	logic [31:0]        imem_wdata;
	logic               wb_valid;
	logic [REG_AW-1:0]  wb_reg;
	logic [31:0]        wb_data;
	logic               st_valid;
	logic [31:0]        st_addr;
	logic [31:0]        st_data;
	logic               exception;
	logic [31:0]        exc_pc;

	// Program under test
	logic [31:0] prog [0:(2**IMEM_AW)-1];
	int          prog_len;

	// Expected commits in program order, kind 1 is a writeback, kind 0 a store
	logic        exp_kind [0:MAX_EVENTS-1];
	logic [31:0] exp_a [0:MAX_EVENTS-1];
	logic [31:0] exp_d [0:MAX_EVENTS-1];
	int          exp_count;
	int          exp_idx;
	logic        exp_left;
	logic        exp_is_wb;
	logic [31:0] exp_a_now;
	logic [31:0] exp_d_now;
	logic [31:0] model_exc_pc;
	logic [31:0] model_dmem [0:(2**DMEM_AW)-1];

	logic        loading;
	int          err_count;
	int          tests_passed;
	int          tests_failed;
	int          inst_total;
	int          cycles;
	int          kind;
	integer      seed = 32'h1853;
	logic [31:0] rnd;
	funct_e      funct_list [0:5] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
	opcode_e     op_list [0:6] = '{OP_ADDIU, OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

	// Period 8
	always #4 clk = ~clk;

	mips_core u_mips_core (
		.clk(clk), .rst(rst), .run(run),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
		.st_valid(st_valid), .st_addr(st_addr), .st_data(st_data),
		.exception(exception), .exc_pc(exc_pc)
	);

	//--------------------------------------------------
	// Commit checking
	//--------------------------------------------------
	assign exp_left = (exp_idx < exp_count);
	assign exp_is_wb = exp_kind[exp_idx];
	assign exp_a_now = exp_a[exp_idx];
	assign exp_d_now = exp_d[exp_idx];

	// Each commit consumes one expected event
	always @(posedge clk)
	begin
		if (rst)
			exp_idx <= 0;
		else if ((wb_valid || st_valid) && exp_left)
			exp_idx <= exp_idx + 1;
	end

	a_idle: assert property (@(posedge clk) disable iff (rst)
		loading |-> (!wb_valid && !st_valid && !exception))
		else begin
			$display("Core committed or trapped at %0t before run rose", $time);
			err_count = err_count + 1;
		end

	a_no_r0: assert property (@(posedge clk) disable iff (rst) wb_valid |-> (wb_reg != '0))
		else begin
			$display("Writeback to register r0 at %0t", $time);
			err_count = err_count + 1;
		end

	a_wb_order: assert property (@(posedge clk) disable iff (rst)
		wb_valid |-> (exp_left && exp_is_wb))
		else begin
			$display("Writeback at %0t where the model has no writeback next", $time);
			err_count = err_count + 1;
		end

	a_wb_reg: assert property (@(posedge clk) disable iff (rst)
		(wb_valid && exp_left && exp_is_wb) |-> (wb_reg == exp_a_now[REG_AW-1:0]))
		else begin
			$display("MISMATCH at %0t: wb_reg expected %0d, actual %0d", $time,
				$sampled(exp_a_now[REG_AW-1:0]), $sampled(wb_reg));
			err_count = err_count + 1;
		end

	a_wb_data: assert property (@(posedge clk) disable iff (rst)
		(wb_valid && exp_left && exp_is_wb) |-> (wb_data == exp_d_now))
		else begin
			$display("MISMATCH at %0t: wb_data expected %h, actual %h", $time,
				$sampled(exp_d_now), $sampled(wb_data));
			err_count = err_count + 1;
		end

	a_st_order: assert property (@(posedge clk) disable iff (rst)
		st_valid |-> (exp_left && !exp_is_wb))
		else begin
			$display("Store at %0t where the model has no store next", $time);
			err_count = err_count + 1;
		end

	a_st_addr: assert property (@(posedge clk) disable iff (rst)
		(st_valid && exp_left && !exp_is_wb) |-> (st_addr == exp_a_now))
		else begin
			$display("MISMATCH at %0t: st_addr expected %h, actual %h", $time,
				$sampled(exp_a_now), $sampled(st_addr));
			err_count = err_count + 1;
		end

	a_st_data: assert property (@(posedge clk) disable iff (rst)
		(st_valid && exp_left && !exp_is_wb) |-> (st_data == exp_d_now))
		else begin
			$display("MISMATCH at %0t: st_data expected %h, actual %h", $time,
				$sampled(exp_d_now), $sampled(st_data));
			err_count = err_count + 1;
		end

	//--------------------------------------------------
	// Instruction encoding and program building
	//--------------------------------------------------
	function automatic logic [31:0] rtype(input funct_e fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {6'b000000, rs, rt, rd, 5'b00000, fn};
	endfunction

	// Operand order as in assembly, rt first
	function automatic logic [31:0] itype(input opcode_e op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jtype(input logic [25:0] target);
		return {OP_J, target};
	endfunction

	task automatic append_inst(input logic [31:0] inst);
		prog[prog_len] = inst;
		prog_len++;
	endtask

	task automatic push_event(input logic is_wb, input logic [31:0] a, input logic [31:0] d);
		if (exp_count < MAX_EVENTS - 1)
		begin
			exp_kind[exp_count] = is_wb;
			exp_a[exp_count] = a;
			exp_d[exp_count] = d;
			exp_count++;
		end
	endtask

	//--------------------------------------------------
	// ISA reference model
	//--------------------------------------------------
	task automatic model_run();
		logic [31:0] r [0:31];
		logic [31:0] pc, pc_next, inst, a, b, res, simm, zimm;
		logic [4:0]  dst;
		logic        wr, done;
		int          steps;
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		pc = '0;
		exp_count = 0;
		model_exc_pc = 'x;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000)
		begin
			inst = prog[pc[IMEM_AW+1:2]];
			a = r[inst[25:21]];
			b = r[inst[20:16]];
			simm = {{16{inst[15]}}, inst[15:0]};
			zimm = {16'h0000, inst[15:0]};
			pc_next = pc + 32'd4;
			dst = inst[20:16];
			wr = 1'b1;
			res = '0;
			case (inst[31:26])
				OP_R:
				begin
					dst = inst[15:11];
					case (inst[5:0])
						FN_ADDU: res = a + b;
						FN_SUBU: res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_XOR:  res = a ^ b;
						FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				OP_ADDI, OP_ADDIU: res = a + simm;
				OP_SLTI: res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
				OP_ANDI: res = a & zimm;
				OP_ORI:  res = a | zimm;
				OP_XORI: res = a ^ zimm;
				OP_LUI:  res = {inst[15:0], 16'h0000};
				OP_LW:   res = model_dmem[(a + simm) >> 2 & 32'hFF];
				OP_SW:
				begin
					wr = 1'b0;
					push_event(1'b0, a + simm, b);
					model_dmem[(a + simm) >> 2 & 32'hFF] = b;
				end
				OP_BEQ:
				begin
					wr = 1'b0;
					if (a == b)
						pc_next = pc + 32'd4 + (simm << 2);
				end
				OP_BNE:
				begin
					wr = 1'b0;
					if (a != b)
						pc_next = pc + 32'd4 + (simm << 2);
				end
				OP_J:
				begin
					wr = 1'b0;
					pc_next = {pc_next[31:28], inst[25:0], 2'b00};
				end
				default:
				begin
					wr = 1'b0;
					done = 1'b1;
					model_exc_pc = pc;
				end
			endcase
			if (wr && dst != 5'd0)
			begin
				r[dst] = res;
				push_event(1'b1, {27'd0, dst}, res);
			end
			pc = pc_next;
			steps++;
		end
	endtask

	//--------------------------------------------------
	// Test sequencing
	//--------------------------------------------------
	task automatic load_program();
		for (int i = 0; i < prog_len; i++)
		begin
			@(negedge clk);
			imem_we = 1'b1;
			imem_addr = i[IMEM_AW-1:0];
			imem_wdata = prog[i];
		end
		@(negedge clk);
		imem_we = 1'b0;
	endtask

	task automatic run_test(input string name, input int idle_cycles);
		int err_before;
		err_before = err_count;
		inst_total += prog_len;
		@(negedge clk);
		rst = 1'b1;
		run = 1'b0;
		loading = 1'b1;
		model_run();
		repeat (4) @(negedge clk);
		rst = 1'b0;
		load_program();
		repeat (idle_cycles) @(negedge clk);
		run = 1'b1;
		loading = 1'b0;
		// Every program ends in an illegal opcode
		while (!exception)
			@(negedge clk);
		// Let older instructions drain
		repeat (3) @(negedge clk);
		run = 1'b0;
		a_all_done: assert (exp_idx == exp_count)
			else begin
				$display("%s saw %0d of %0d expected commits", name, exp_idx, exp_count);
				err_count = err_count + 1;
			end
		a_exc_pc: assert (exc_pc == model_exc_pc)
			else begin
				$display("MISMATCH at %0t: exc_pc expected %h, actual %h", $time,
					model_exc_pc, exc_pc);
				err_count = err_count + 1;
			end
		if (err_count == err_before)
		begin
			tests_passed++;
			$display("Test %-10s passed, %0d commits", name, exp_count);
		end
		else
		begin
			tests_failed++;
			$display("Test %-10s failed", name);
		end
	endtask

	initial
	begin
		rst = 1'b1;
		run = 1'b0;
		loading = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;

		// Reset state, idle with run low, r0 write suppressed
		prog_len = 0;
		append_inst(itype(OP_ADDIU, 0, 0, 16'd5));
		append_inst(itype(OP_ADDIU, 1, 0, 16'd7));
		append_inst(rtype(FN_ADDU, 2, 1, 1));
		append_inst(STOP_INST);
		run_test("reset", 12);

		// ALU and immediates with back-to-back dependencies
		prog_len = 0;
		append_inst(itype(OP_ADDIU, 1, 0, 16'hFFFD));
		append_inst(itype(OP_ADDI, 2, 0, 16'd100));
		append_inst(rtype(FN_ADDU, 3, 1, 2));
		append_inst(rtype(FN_SUBU, 4, 3, 1));
		append_inst(rtype(FN_AND, 5, 4, 2));
		append_inst(rtype(FN_OR, 6, 1, 2));
		append_inst(rtype(FN_XOR, 7, 6, 3));
		append_inst(rtype(FN_SLT, 8, 1, 2));
		append_inst(rtype(FN_SLT, 9, 2, 1));
		append_inst(itype(OP_ANDI, 10, 1, 16'hF0F0));
		append_inst(itype(OP_ORI, 11, 0, 16'h8001));
		append_inst(itype(OP_XORI, 12, 11, 16'hFFFF));
		append_inst(itype(OP_SLTI, 13, 1, 16'hFFFE));
		append_inst(itype(OP_LUI, 14, 0, 16'hABCD));
		append_inst(itype(OP_ADDIU, 15, 14, 16'h8000));
		append_inst(rtype(FN_SUBU, 0, 1, 2));
		append_inst(STOP_INST);
		run_test("alu", 2);

		// Stores, loads back and load-use
		prog_len = 0;
		append_inst(itype(OP_ADDIU, 1, 0, 16'h0040));
		append_inst(itype(OP_LUI, 2, 0, 16'h1234));
		append_inst(itype(OP_ORI, 2, 2, 16'h5678));
		append_inst(itype(OP_SW, 2, 1, 16'd8));
		append_inst(itype(OP_SW, 1, 1, 16'hFFFC));
		append_inst(itype(OP_LW, 3, 1, 16'd8));
		append_inst(rtype(FN_ADDU, 4, 3, 3));
		append_inst(itype(OP_LW, 5, 1, 16'hFFFC));
		append_inst(itype(OP_SW, 5, 0, 16'd0));
		append_inst(itype(OP_ADDIU, 6, 5, 16'd1));
		append_inst(STOP_INST);
		run_test("memory", 2);

		// Branches and jump, each squashed slot writes 99
		prog_len = 0;
		append_inst(itype(OP_ADDIU, 1, 0, 16'd5));
		append_inst(itype(OP_ADDIU, 2, 0, 16'd5));
		append_inst(itype(OP_BEQ, 2, 1, 16'd1));
		append_inst(itype(OP_ADDIU, 3, 0, 16'd99));
		append_inst(itype(OP_BNE, 2, 1, 16'd1));
		append_inst(itype(OP_ADDIU, 4, 0, 16'd1));
		append_inst(itype(OP_BNE, 4, 1, 16'd1));
		append_inst(itype(OP_ADDIU, 5, 0, 16'd99));
		append_inst(itype(OP_BEQ, 4, 1, 16'd1));
		append_inst(jtype(26'd11));
		append_inst(itype(OP_ADDIU, 6, 0, 16'd99));
		append_inst(itype(OP_ADDIU, 7, 0, 16'd7));
		// Backward loop counts r8 up to r2
		append_inst(itype(OP_ADDIU, 8, 8, 16'd1));
		append_inst(itype(OP_BNE, 2, 8, 16'hFFFE));
		append_inst(itype(OP_ADDIU, 9, 0, 16'd3));
		append_inst(STOP_INST);
		run_test("branch", 2);

		// Random straight-line ALU program over r0 to r7
		prog_len = 0;
		for (int i = 0; i < RAND_LEN; i++)
		begin
			rnd = $random(seed);
			kind = rnd[15:9] % 13;
			if (kind < 6)
				append_inst(rtype(funct_list[kind], rnd[2:0], rnd[5:3], rnd[8:6]));
			else
				append_inst(itype(op_list[kind-6], rnd[2:0], rnd[5:3], rnd[31:16]));
		end
		append_inst(STOP_INST);
		run_test("random", 2);

		// Illegal opcode with younger instructions behind it
		prog_len = 0;
		append_inst(itype(OP_ADDIU, 1, 0, 16'd11));
		append_inst(itype(OP_SW, 1, 0, 16'h0020));
		append_inst(rtype(FN_ADDU, 2, 1, 1));
		append_inst(32'h7000_0000);
		append_inst(itype(OP_ADDIU, 3, 0, 16'd1));
		append_inst(itype(OP_SW, 3, 0, 16'h0024));
		append_inst(rtype(FN_ADDU, 4, 3, 3));
		run_test("illegal", 2);

		$display("Tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_passed, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog, budget grows with every program that is run
	initial
	begin
		cycles = 0;
		while (cycles <= inst_total * 4 + 100)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the core did not reach its stop opcode", cycles);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== all.f ====
hdl/mips_pkg.sv
hdl/if_stage.sv
hdl/id_regfile.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/mips_core.sv
verif/tb_mips_core.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - files:
      - hdl/mips_pkg.sv
      - hdl/if_stage.sv
      - hdl/id_regfile.sv
      - hdl/id_stage.sv
      - hdl/ex_stage.sv
      - hdl/mips_core.sv
  - target: test
    files:
      - verif/tb_mips_core.sv
